// File: hdl/nocPkg.sv
package nocPkg;

  localparam int portCount = 5;
  localparam int fifoDepthDefault = 4;
  localparam int lenWidthDefault = 12;
  localparam int coordWidth = 2;

  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portId;

  typedef enum logic [2:0] {
    kindIdle = 3'd0,
    kindHead = 3'd1,
    kindBody = 3'd2,
    kindTail = 3'd3
  } flitKind;

  // Bit zero is idle, bit p+1 grants input port p.
  typedef enum logic [5:0] {
    arbIdle  = 6'b000001,
    arbLocal = 6'b000010,
    arbNorth = 6'b000100,
    arbEast  = 6'b001000,
    arbWest  = 6'b010000,
    arbSouth = 6'b100000
  } arbState;

  typedef struct packed {
    flitKind kind;
    logic [coordWidth-1:0] destX;
    logic [coordWidth-1:0] destY;
    logic [lenWidthDefault-1:0] length;  // Hold limit in cycles, read on head flits.
    logic [2:0] srcTag;
    logic [15:0] payload;
  } flit;

  function automatic portId holderOf(arbState grant);
    portId holder;
    holder = portLocal;
    for (int i = 0; i < portCount; i++)
      if (grant[i+1])
        holder = portId'(i);
    return holder;
  endfunction

endpackage

// File: hdl/holdTimer.sv
`timescale 1ns/1ps

module holdTimer #(
  parameter int lenWidth = nocPkg::lenWidthDefault
) (
  input  logic                clk,
  input  logic                rst,
  input  nocPkg::flitKind     kind,
  input  logic [lenWidth-1:0] length,
  input  logic                run,
  output logic                expired
);
  import nocPkg::*;

  logic [lenWidth-1:0] limit;
  logic [lenWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (kind == kindHead)
        limit <= length;  // Every head seen at this input reloads the limit.
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign expired = (count == limit);

endmodule

// File: hdl/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter #(
  parameter int lenWidth = nocPkg::lenWidthDefault
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [nocPkg::portCount-1:0]          req,
  input  nocPkg::flit [nocPkg::portCount-1:0]   headFlit,
  output nocPkg::arbState                       grant
);
  import nocPkg::*;

  arbState state;
  arbState nextState;
  portId holder;
  logic [portCount-1:0] run;
  logic [portCount-1:0] expired;

  // First requester found scanning span ports cyclically from port first.
  function automatic arbState pickFrom(logic [portCount-1:0] r, int first, int span);
    arbState pick;
    int idx;
    pick = arbIdle;
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = (first + k) % portCount;
      if (r[idx])
        pick = arbState'(6'b000010 << idx);
    end
    return pick;
  endfunction

  for (genvar i = 0; i < portCount; i++)
  begin : genTimer
    holdTimer #(
      .lenWidth(lenWidth)
    ) timer (
      .clk     (clk),
      .rst     (rst),
      .kind    (headFlit[i].kind),
      .length  (lenWidth'(headFlit[i].length)),
      .run     (run[i]),
      .expired (expired[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= arbIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    holder = holderOf(state);
    run = '0;
    if (state == arbIdle)
      nextState = pickFrom(req, 0, portCount);  // Lowest port number wins from idle.
    else if (req[holder] && !expired[holder])
    begin
      run[holder] = 1'b1;
      nextState = state;
    end
    else
      nextState = pickFrom(req, int'(holder) + 1, portCount - 1);
  end

  assign grant = state;

  // The crossbar and the input ports both decode this grant as a single holder.
  assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("outputArbiter grant is not one-hot.");

endmodule

// File: hdl/flitFifo.sv
`timescale 1ns/1ps

module flitFifo #(
  parameter int depth = nocPkg::fifoDepthDefault
) (
  input  logic        clk,
  input  logic        rst,
  input  nocPkg::flit wrFlit,
  input  logic        wr,
  input  logic        rd,
  output nocPkg::flit rdFlit,
  output logic        full,
  output logic        empty
);
  import nocPkg::*;

  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;

  flit mem [depth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0] count;

  function automatic logic [ptrWidth-1:0] bump(logic [ptrWidth-1:0] ptr);
    return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wr)
        wrPtr <= bump(wrPtr);
      if (rd)
        rdPtr <= bump(rdPtr);
      if (wr && !rd)
        count <= count + 1'b1;
      else if (rd && !wr)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr)
      mem[wrPtr] <= wrFlit;
  end

  assign rdFlit = mem[rdPtr];  // The head flit shows without a read.
  assign full = (count == (ptrWidth + 1)'(depth));
  assign empty = (count == '0);

  assert property (@(posedge clk) disable iff (rst) wr |-> !full)
    else $error("flitFifo written while full.");
  assert property (@(posedge clk) disable iff (rst) rd |-> !empty)
    else $error("flitFifo read while empty.");

endmodule

// File: hdl/inputPort.sv
`timescale 1ns/1ps

module inputPort #(
  parameter int routerX = 0,
  parameter int routerY = 0,
  parameter int depth = nocPkg::fifoDepthDefault
) (
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::flit                  inFlit,
  input  logic                         inValid,
  output logic                         inFull,
  input  logic [nocPkg::portCount-1:0] granted,
  output nocPkg::flit                  headFlit,
  output logic [nocPkg::portCount-1:0] req,
  output nocPkg::flit                  popFlit
);
  import nocPkg::*;

  flit fifoFlit;
  logic empty;
  logic pop;
  logic reqOn;
  logic routeValid;
  portId headRoute;
  portId route;
  portId activeRoute;

  flitFifo #(
    .depth(depth)
  ) fifo (
    .clk    (clk),
    .rst    (rst),
    .wrFlit (inFlit),
    .wr     (inValid && (inFlit.kind != kindIdle)),
    .rd     (pop),
    .rdFlit (fifoFlit),
    .full   (inFull),
    .empty  (empty)
  );

  // XY routing: X is resolved first, then Y.
  always_comb
  begin
    if (int'(fifoFlit.destX) > routerX)
      headRoute = portEast;
    else if (int'(fifoFlit.destX) < routerX)
      headRoute = portWest;
    else if (int'(fifoFlit.destY) > routerY)
      headRoute = portNorth;
    else if (int'(fifoFlit.destY) < routerY)
      headRoute = portSouth;
    else
      headRoute = portLocal;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      routeValid <= 1'b0;
      route <= portLocal;
    end
    else if (pop)
    begin
      if (fifoFlit.kind == kindHead)
      begin
        route <= headRoute;
        routeValid <= 1'b1;
      end
      else if (fifoFlit.kind == kindTail)
        routeValid <= 1'b0;  // Packet done, the next head routes afresh.
    end
  end

  assign activeRoute = (fifoFlit.kind == kindHead) ? headRoute : route;
  assign reqOn = !empty && ((fifoFlit.kind == kindHead) || routeValid);
  assign req = reqOn ? (portCount'(1) << activeRoute) : '0;

  // A grant left over from the previous packet's output does not pop.
  assign pop = !empty && |(granted & req);

  assign headFlit = empty ? '0 : fifoFlit;
  assign popFlit = pop ? fifoFlit : '0;  // Idle kind when nothing leaves.

endmodule

// File: hdl/crossbarSwitch.sv
`timescale 1ns/1ps

module crossbarSwitch (
  input  logic                                    clk,
  input  logic                                    rst,
  input  nocPkg::flit [nocPkg::portCount-1:0]     popFlit,
  input  nocPkg::arbState [nocPkg::portCount-1:0] grant,
  input  logic [nocPkg::portCount-1:0]            popped,
  output nocPkg::flit [nocPkg::portCount-1:0]     outFlit,
  output logic [nocPkg::portCount-1:0]            outValid
);
  import nocPkg::*;

  portId src [portCount];
  logic [portCount-1:0] forward;

  always_comb
  begin
    for (int o = 0; o < portCount; o++)
    begin
      src[o] = holderOf(grant[o]);
      forward[o] = (grant[o] != arbIdle) && popped[src[o]];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= '0;
    else
      outValid <= forward;
  end

  // Outputs hold their last flit while nothing is forwarded.
  always_ff @(posedge clk)
  begin
    for (int o = 0; o < portCount; o++)
    begin
      if (forward[o])
        outFlit[o] <= popFlit[src[o]];
    end
  end

endmodule

// File: hdl/meshRouter.sv
`timescale 1ns/1ps

module meshRouter #(
  parameter int routerX = 1,
  parameter int routerY = 1,
  parameter int fifoDepth = nocPkg::fifoDepthDefault,
  parameter int lenWidth = nocPkg::lenWidthDefault
) (
  input  logic                                clk,
  input  logic                                rst,
  input  nocPkg::flit [nocPkg::portCount-1:0] inFlit,
  input  logic [nocPkg::portCount-1:0]        inValid,
  output logic [nocPkg::portCount-1:0]        inFull,
  output nocPkg::flit [nocPkg::portCount-1:0] outFlit,
  output logic [nocPkg::portCount-1:0]        outValid
);
  import nocPkg::*;

  logic [portCount-1:0][portCount-1:0] reqVec;   // Indexed [input][output].
  logic [portCount-1:0][portCount-1:0] reqTo;    // Indexed [output][input].
  logic [portCount-1:0][portCount-1:0] grantTo;  // Indexed [input][output].
  logic [portCount-1:0] popped;
  flit [portCount-1:0] headFlit;
  flit [portCount-1:0] popFlit;
  arbState [portCount-1:0] grant;

  always_comb
  begin
    for (int i = 0; i < portCount; i++)
    begin
      popped[i] = (popFlit[i].kind != kindIdle);
      for (int o = 0; o < portCount; o++)
      begin
        reqTo[o][i] = reqVec[i][o];
        grantTo[i][o] = grant[o][i+1];
      end
    end
  end

  for (genvar i = 0; i < portCount; i++)
  begin : genInput
    inputPort #(
      .routerX (routerX),
      .routerY (routerY),
      .depth   (fifoDepth)
    ) port (
      .clk      (clk),
      .rst      (rst),
      .inFlit   (inFlit[i]),
      .inValid  (inValid[i]),
      .inFull   (inFull[i]),
      .granted  (grantTo[i]),
      .headFlit (headFlit[i]),
      .req      (reqVec[i]),
      .popFlit  (popFlit[i])
    );
  end

  for (genvar o = 0; o < portCount; o++)
  begin : genOutput
    outputArbiter #(
      .lenWidth(lenWidth)
    ) arb (
      .clk      (clk),
      .rst      (rst),
      .req      (reqTo[o]),
      .headFlit (headFlit),
      .grant    (grant[o])
    );
  end

  crossbarSwitch xbar (
    .clk      (clk),
    .rst      (rst),
    .popFlit  (popFlit),
    .grant    (grant),
    .popped   (popped),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

// File: test/routerTb.sv
`timescale 1ns/1ps

module routerTb;
  import nocPkg::*;

  localparam int routerX = 1;
  localparam int routerY = 1;
  localparam int packetsPerPort = 8;
  localparam int waitLimit = 20000;

  logic clk;
  logic rst;
  flit [portCount-1:0] inFlit = '0;
  logic [portCount-1:0] inValid = '0;
  logic [portCount-1:0] inFull;
  flit [portCount-1:0] outFlit;
  logic [portCount-1:0] outValid;

  flit stimQ [portCount][$];
  flit expQ [portCount][portCount][$];  // Indexed [source][output].
  logic [portCount-1:0] wrote = '0;
  logic [portCount-1:0] openSrc [portCount] = '{default: '0};
  logic go = 1'b0;
  logic injected = 1'b0;
  logic [15:0] seqNo = '0;
  int switchCount = 0;
  int monErrors = 0;
  int endErrors = 0;
  bit timedOut = 1'b0;

  meshRouter #(
    .routerX (routerX),
    .routerY (routerY)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inFull   (inFull),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // X is resolved before Y. Equal coordinates deliver locally.
  function automatic portId xyRoute(logic [1:0] dx, logic [1:0] dy);
    if (int'(dx) > routerX)
      return portEast;
    else if (int'(dx) < routerX)
      return portWest;
    else if (int'(dy) > routerY)
      return portNorth;
    else if (int'(dy) < routerY)
      return portSouth;
    return portLocal;
  endfunction

  function automatic int pendingCount();
    int total;
    total = 0;
    for (int s = 0; s < portCount; s++)
    begin
      total += stimQ[s].size();
      for (int o = 0; o < portCount; o++)
        total += expQ[s][o].size();
    end
    return total;
  endfunction

  // A source pops in FIFO order, so its oldest pending flit is the next to leave.
  function automatic int nextOutput(int s);
    int best;
    logic [15:0] oldest;
    best = -1;
    oldest = '0;
    for (int o = 0; o < portCount; o++)
    begin
      if (expQ[s][o].size() > 0 && (best < 0 || expQ[s][o][0].payload < oldest))
      begin
        best = o;
        oldest = expQ[s][o][0].payload;
      end
    end
    return best;
  endfunction

  task automatic checkFlit(input string name, input flit got, input flit exp);
    if (got !== exp)
    begin
      monErrors++;
      $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
    end
  endtask

  task automatic checkPort(input string name, input portId got, input portId exp);
    if (got !== exp)
    begin
      monErrors++;
      $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
    end
  endtask

  task automatic checkValid(input string name, input logic [portCount-1:0] got,
                            input logic [portCount-1:0] exp);
    if (got !== exp)
    begin
      monErrors++;
      $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
    end
  endtask

  // Queues head, bodies and tail, then idle slots that space the next packet.
  task automatic addPacket(input portId src, input logic [1:0] dx, input logic [1:0] dy,
                           input int len, input int bodies, input int gap);
    flit f;
    f.destX = dx;
    f.destY = dy;
    f.length = 12'(len);
    f.srcTag = src;
    for (int n = 0; n < bodies + 2 + gap; n++)
    begin
      if (n == 0)
        f.kind = kindHead;
      else if (n <= bodies)
        f.kind = kindBody;
      else if (n == bodies + 1)
        f.kind = kindTail;
      else
        f.kind = kindIdle;
      f.payload = seqNo;
      seqNo++;
      stimQ[src].push_back(f);
    end
  endtask

  task automatic waitIdle(input string phase);
    int cycles;
    cycles = 0;
    while (pendingCount() != 0 && cycles < waitLimit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (pendingCount() != 0)
    begin
      timedOut = 1'b1;
      endErrors++;
      $display("Timeout in %s phase: %0d flits never arrived.", phase, pendingCount());
    end
    else
      repeat (8) @(negedge clk);  // Lets any stray flit show up.
  endtask

  // The inFull seen here misses the write taken at this edge, so a port writes every other cycle.
  always @(posedge clk)
  begin
    flit f;
    for (int p = 0; p < portCount; p++)
    begin
      if (!rst && go && !wrote[p] && !inFull[p] && stimQ[p].size() > 0)
      begin
        f = stimQ[p].pop_front();
        inFlit[p] <= f;
        inValid[p] <= (f.kind != kindIdle);
        wrote[p] <= (f.kind != kindIdle);
        if (f.kind != kindIdle)
        begin
          expQ[int'(f.srcTag)][int'(xyRoute(f.destX, f.destY))].push_back(f);
          injected <= 1'b1;
        end
      end
      else
      begin
        inValid[p] <= 1'b0;
        wrote[p] <= 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    flit got;
    flit exp;
    int s;
    int x;
    if (!rst)
    begin
      if (!injected)
      begin
        checkValid("outValid", outValid, '0);
        checkValid("inFull", inFull, '0);
      end
      for (int o = 0; o < portCount; o++)
      begin
        if (outValid[o])
        begin
          got = outFlit[o];
          s = int'(got.srcTag);
          if (s >= portCount)
          begin
            monErrors++;
            $display("Flit with a bad source tag %0d left output %0d.", s, o);
          end
          else
          begin
            x = nextOutput(s);
            if (x < 0)
            begin
              monErrors++;
              $display("Unexpected flit from source %0d left output %0d.", s, o);
            end
            else
            begin
              checkPort($sformatf("output of source %0d", s), portId'(o), portId'(x));
              exp = expQ[s][x].pop_front();
              checkFlit($sformatf("outFlit[%0d]", o), got, exp);
              if ((openSrc[o] & ~(portCount'(1) << s)) != '0)
                switchCount++;  // Another source's packet is still open here.
              openSrc[o][s] = (got.kind != kindTail);
            end
          end
        end
      end
    end
  end

  initial
  begin
    int startSwitches;
    logic [1:0] dx;
    logic [1:0] dy;
    int len;
    int bodies;
    int gap;
    rst = 1'b1;
    void'($urandom(32'hc1f3ee72));
    for (int n = 0; n < packetsPerPort; n++)
    begin
      for (int p = 0; p < portCount; p++)
      begin
        dx = 2'($urandom_range(3, 0));
        dy = 2'($urandom_range(3, 0));
        len = int'($urandom_range(6, 0));
        bodies = int'($urandom_range(4, 0));
        gap = int'($urandom_range(3, 0));
        addPacket(portId'(p), dx, dy, len, bodies, gap);
      end
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (6) @(posedge clk);  // Outputs must stay quiet before any injection.
    go <= 1'b1;
    waitIdle("random traffic");
    if (!timedOut)
    begin
      startSwitches = switchCount;
      addPacket(portNorth, 2'd1, 2'd1, 0, 4, 0);
      addPacket(portEast, 2'd1, 2'd1, 0, 4, 0);
      waitIdle("zero-length contention");
      if (!timedOut && switchCount == startSwitches)
      begin
        endErrors++;
        $display("Zero-length packets at the Local output never interleaved.");
      end
    end
    $display("Router run done: %0d check errors, %0d run errors.", monErrors, endErrors);
    if (monErrors + endErrors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: build.f
hdl/nocPkg.sv
hdl/holdTimer.sv
hdl/outputArbiter.sv
hdl/flitFifo.sv
hdl/inputPort.sv
hdl/crossbarSwitch.sv
hdl/meshRouter.sv
test/routerTb.sv

// File: Makefile
TOP = routerTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

# The run passes only when the pass line shows up in the output.
sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
